// File: common/mem_stage_pkg.sv
package mem_stage_pkg;

    // cp0 cause codes raised by the memory stage
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_MOD  = 5'd1,
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_OV   = 5'd12,
        EXC_TR   = 5'd13
    } exc_code_e;

    // ll shares OP_LW, sc shares OP_SW
    typedef enum logic [3:0] {
        OP_SB  = 4'd0,
        OP_SH  = 4'd1,
        OP_SW  = 4'd2,
        OP_SWL = 4'd3,
        OP_SWR = 4'd4,
        OP_LBU = 4'd5,
        OP_LB  = 4'd6,
        OP_LHU = 4'd7,
        OP_LH  = 4'd8,
        OP_LWL = 4'd9,
        OP_LWR = 4'd10,
        OP_LW  = 4'd11
    } mem_op_e;

    typedef struct packed {
        logic [31:0] vaddr;
        mem_op_e     op;
        logic        is_load;
        logic        is_store;
        logic        is_ll;
        logic        is_sc;
        logic [31:0] store_data;    // rt value
    } mem_req_t;

    typedef struct packed {
        logic        found;
        logic        valid;
        logic        dirty;
        logic [19:0] pfn;
        logic [2:0]  cca;
    } tlb_resp_t;

    typedef struct packed {
        logic        status_bev;
        logic        status_exl;
        logic        cause_iv;
        logic [2:0]  config_k0;
        logic [31:0] ebase;
        logic [31:0] epc;
    } cp0_state_t;

    typedef struct packed {
        logic        exception;
        logic        refill;
        exc_code_e   code;
        logic [31:0] badvaddr;
    } exc_info_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic        uncached;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic [4:0]  rstrb;     // load extract code
        logic [1:0]  size;
    } bus_req_t;

    localparam logic [2:0] CCA_CACHEABLE = 3'd3;

endpackage

// File: mem_stage/addr_translate.sv
`timescale 1ns/1ps

module addr_translate import mem_stage_pkg::*; (
    input  logic [31:0] vaddr,
    input  logic        is_access,
    input  tlb_resp_t   tlb,
    input  logic [2:0]  config_k0,
    output logic        mapped,
    output logic [31:0] paddr,
    output logic        uncached
);

    logic kseg0;
    logic kseg1;

    // kuseg and kseg2/3 go through the tlb
    assign mapped = (~vaddr[31] | (vaddr[31:30] == 2'b11)) & is_access;

    assign paddr = mapped ? {tlb.pfn, vaddr[11:0]}
                          : {3'b000, vaddr[28:0]};

    assign kseg0 = (vaddr[31:29] == 3'b100);
    assign kseg1 = (vaddr[31:29] == 3'b101);

    always_comb begin
        if (kseg1)
            uncached = 1'b1;
        else if (kseg0)
            uncached = (config_k0 != CCA_CACHEABLE);    // k0 field decides
        else if (mapped)
            uncached = (tlb.cca != CCA_CACHEABLE);
        else
            uncached = 1'b0;
    end

endmodule

// File: mem_stage/except_detect.sv
`timescale 1ns/1ps

module except_detect import mem_stage_pkg::*; (
    input  mem_req_t    req,
    input  logic        mapped,
    input  tlb_resp_t   tlb,
    input  logic        sc_ok,
    input  logic        prior_exc,
    input  exc_code_e   prior_code,
    input  logic [31:0] pc,
    input  logic        overflow,
    input  logic        trap,
    input  logic        interrupt,
    input  logic        eret,
    output exc_info_t   exc,
    output logic        flush_any
);

    logic tlb_miss;
    logic tlbl;
    logic tlbs;
    logic tlbmod;
    logic store_writes;
    logic ades;
    logic adel;

    // sc without a link does not write, so it cannot take a mod fault
    assign store_writes = req.is_store & (~req.is_sc | sc_ok);

    assign tlb_miss = mapped & (~tlb.found | ~tlb.valid);
    assign tlbl     = tlb_miss & req.is_load;
    assign tlbs     = tlb_miss & req.is_store;
    assign tlbmod   = mapped & tlb.found & tlb.valid & ~tlb.dirty & store_writes;

    assign ades = req.is_store & (((req.op == OP_SW) & (req.vaddr[1:0] != 2'b00)) |
                                  ((req.op == OP_SH) & req.vaddr[0]));
    assign adel = req.is_load & (((req.op == OP_LW) & (req.vaddr[1:0] != 2'b00)) |
                                 (((req.op == OP_LH) | (req.op == OP_LHU)) & req.vaddr[0]));

    always_comb begin
        exc.exception = interrupt | prior_exc | overflow | trap | ades | adel |
                        tlbl | tlbs | tlbmod;
        exc.refill    = mapped & (req.is_load | req.is_store) & ~tlb.found & ~prior_exc;
        if (interrupt) begin
            exc.code     = EXC_INT;
            exc.badvaddr = 32'd0;
        end else if (prior_exc) begin
            exc.code     = prior_code;
            exc.badvaddr = pc;  // earlier stages report their pc
        end else if (overflow) begin
            exc.code     = EXC_OV;
            exc.badvaddr = 32'd0;
        end else if (trap) begin
            exc.code     = EXC_TR;
            exc.badvaddr = 32'd0;
        end else if (ades) begin
            exc.code     = EXC_ADES;
            exc.badvaddr = req.vaddr;
        end else if (adel) begin
            exc.code     = EXC_ADEL;
            exc.badvaddr = req.vaddr;
        end else begin
            exc.code     = tlbl ? EXC_TLBL : (tlbs ? EXC_TLBS : EXC_MOD);
            exc.badvaddr = req.vaddr;
        end
        // refill vector only makes sense with an exception taken
        assert (!exc.refill || exc.exception);
    end

    assign flush_any = exc.exception | eret;

endmodule

// File: mem_stage/ll_sc_monitor.sv
`timescale 1ns/1ps

module ll_sc_monitor import mem_stage_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        is_ll,
    input  logic        is_sc,
    input  logic [31:0] vaddr,
    input  logic        flush_any,
    output logic        sc_ok
);

    logic        link_q;
    logic [31:0] link_addr;

    always_ff @(posedge clk) begin
        if (rst || flush_any)
            link_q <= 1'b0;
        else if (is_ll)
            link_q <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (is_ll && !flush_any)
            link_addr <= vaddr;
    end

    assign sc_ok = is_sc & link_q & (link_addr == vaddr);

    // link must come from an ll that retired in an earlier cycle
    a_sc_after_ll: assert property (@(posedge clk) disable iff (rst)
        sc_ok |-> $past(link_q | (is_ll & ~flush_any)));

endmodule

// File: mem_stage/access_align.sv
`timescale 1ns/1ps

module access_align import mem_stage_pkg::*; (
    input  mem_op_e     op,
    input  logic [1:0]  offset,
    input  logic [31:0] store_data,
    output logic [3:0]  wstrb,
    output logic [31:0] wdata,
    output logic [4:0]  rstrb,
    output logic [1:0]  size
);

    always_comb begin
        case (op)
            OP_SB:   wstrb = 4'b0001 << offset;
            OP_SH:   wstrb = offset[1] ? 4'b1100 : 4'b0011;
            OP_SWL: begin
                case (offset)
                    2'd0:    wstrb = 4'b0001;
                    2'd1:    wstrb = 4'b0011;
                    2'd2:    wstrb = 4'b0111;
                    default: wstrb = 4'b1111;
                endcase
            end
            OP_SWR: begin
                case (offset)
                    2'd0:    wstrb = 4'b1111;
                    2'd1:    wstrb = 4'b1110;
                    2'd2:    wstrb = 4'b1100;
                    default: wstrb = 4'b1000;
                endcase
            end
            default: wstrb = 4'b1111;   // sw, sc and loads
        endcase
        assert (wstrb != 4'b0000);
    end

    always_comb begin
        case (op)
            OP_SB:   wdata = {4{store_data[7:0]}};
            OP_SH:   wdata = {2{store_data[15:0]}};
            OP_SWL: begin
                // upper bytes of rt land at the low end
                case (offset)
                    2'd0:    wdata = {4{store_data[31:24]}};
                    2'd1:    wdata = {2{store_data[31:16]}};
                    2'd2:    wdata = {8'h00, store_data[31:8]};
                    default: wdata = store_data;
                endcase
            end
            OP_SWR: begin
                case (offset)
                    2'd0:    wdata = store_data;
                    2'd1:    wdata = {store_data[23:0], 8'h00};
                    2'd2:    wdata = {2{store_data[15:0]}};
                    default: wdata = {4{store_data[7:0]}};
                endcase
            end
            default: wdata = store_data;
        endcase
    end

    always_comb begin
        case (op)
            OP_LBU:  rstrb = {3'b000, offset};
            OP_LB:   rstrb = {3'b010, offset};          // bit 3 means sign extend
            OP_LHU:  rstrb = {3'b001, offset[1], 1'b0};
            OP_LH:   rstrb = {3'b011, offset[1], 1'b0};
            OP_LWL: begin
                case (offset)
                    2'd0:    rstrb = 5'b11000;
                    2'd1:    rstrb = 5'b11100;
                    2'd2:    rstrb = 5'b11110;
                    default: rstrb = 5'b11111;
                endcase
            end
            OP_LWR: begin
                case (offset)
                    2'd0:    rstrb = 5'b11111;
                    2'd1:    rstrb = 5'b10111;
                    2'd2:    rstrb = 5'b10011;
                    default: rstrb = 5'b10001;
                endcase
            end
            default: rstrb = 5'b11111;
        endcase
    end

    always_comb begin
        case (op)
            OP_SB, OP_LBU, OP_LB: size = 2'd0;
            OP_SH, OP_LHU, OP_LH: size = 2'd1;
            default:              size = 2'd2;  // word and partial word
        endcase
    end

endmodule

// File: hw/exc_vector.sv
`timescale 1ns/1ps

module exc_vector import mem_stage_pkg::*; #(
    parameter logic [31:0] BEV_BASE = 32'hbfc00200
) (
    input  logic        eret,
    input  logic        interrupt,
    input  logic        refill,
    input  cp0_state_t  cp0,
    output logic [31:0] redirect_pc
);

    logic [11:0] vec_offset;

    // nested exceptions always use the general vector
    always_comb begin
        if (!cp0.status_exl && refill)
            vec_offset = 12'h000;
        else if (!cp0.status_exl && interrupt && cp0.cause_iv)
            vec_offset = 12'h200;
        else
            vec_offset = 12'h180;
    end

    always_comb begin
        if (eret)
            redirect_pc = cp0.epc;
        else if (cp0.status_bev)
            redirect_pc = BEV_BASE + {20'd0, vec_offset};
        else
            redirect_pc = {cp0.ebase[31:12], vec_offset};
    end

endmodule

// File: hw/mem_access_stage.sv
`timescale 1ns/1ps

module mem_access_stage import mem_stage_pkg::*; #(
    parameter logic [31:0] BEV_BASE = 32'hbfc00200
) (
    input  logic       clk,
    input  logic       rst,
    input  mem_req_t   req,
    input  tlb_resp_t  tlb,
    input  cp0_state_t cp0,
    input  logic       prior_exc,
    input  exc_code_e  prior_code,
    input  logic [31:0] pc,
    input  logic       overflow,
    input  logic       trap,
    input  logic       interrupt,
    input  logic       eret,
    output bus_req_t   bus,
    output logic       mem_en,
    output exc_info_t  exc,
    output logic       redirect,
    output logic [31:0] redirect_pc
);

    logic        is_access;
    logic        mapped;
    logic [31:0] paddr;
    logic        uncached;
    logic        sc_ok;
    logic        flush_any;
    logic [3:0]  wstrb;
    logic [31:0] wdata;
    logic [4:0]  rstrb;
    logic [1:0]  size;

    assign is_access = req.is_load | req.is_store;

    addr_translate i_addr_translate (
        .vaddr     (req.vaddr),
        .is_access (is_access),
        .tlb       (tlb),
        .config_k0 (cp0.config_k0),
        .mapped    (mapped),
        .paddr     (paddr),
        .uncached  (uncached)
    );

    except_detect i_except_detect (
        .req        (req),
        .mapped     (mapped),
        .tlb        (tlb),
        .sc_ok      (sc_ok),
        .prior_exc  (prior_exc),
        .prior_code (prior_code),
        .pc         (pc),
        .overflow   (overflow),
        .trap       (trap),
        .interrupt  (interrupt),
        .eret       (eret),
        .exc        (exc),
        .flush_any  (flush_any)
    );

    ll_sc_monitor i_ll_sc_monitor (
        .clk       (clk),
        .rst       (rst),
        .is_ll     (req.is_ll),
        .is_sc     (req.is_sc),
        .vaddr     (req.vaddr),
        .flush_any (flush_any),
        .sc_ok     (sc_ok)
    );

    access_align i_access_align (
        .op         (req.op),
        .offset     (paddr[1:0]),
        .store_data (req.store_data),
        .wstrb      (wstrb),
        .wdata      (wdata),
        .rstrb      (rstrb),
        .size       (size)
    );

    exc_vector #(
        .BEV_BASE (BEV_BASE)
    ) i_exc_vector (
        .eret        (eret),
        .interrupt   (interrupt),
        .refill      (exc.refill),
        .cp0         (cp0),
        .redirect_pc (redirect_pc)
    );

    assign bus = '{paddr: paddr, uncached: uncached, wstrb: wstrb,
                   wdata: wdata, rstrb: rstrb, size: size};

    // a failed sc never reaches memory
    assign mem_en   = is_access & ~flush_any & (~req.is_sc | sc_ok);
    assign redirect = flush_any;

endmodule

// File: bench/tb_mem_access_stage.sv
`timescale 1ns/1ps

module tb_mem_access_stage import mem_stage_pkg::*; ();

    localparam int NREC      = 32;
    localparam int WORDS     = 15;     // hex words per record
    localparam int RST_CYC   = 5;
    localparam int MAX_CYC   = RST_CYC + NREC + 20;

    logic        clk;
    logic        rst;
    mem_req_t    req;
    tlb_resp_t   tlb;
    cp0_state_t  cp0;
    logic        prior_exc;
    exc_code_e   prior_code;
    logic [31:0] pc;
    logic        overflow;
    logic        trap;
    logic        interrupt;
    logic        eret;
    bus_req_t    bus;
    logic        mem_en;
    exc_info_t   exc;
    logic        redirect;
    logic [31:0] redirect_pc;

    logic [31:0] pat [0:NREC*WORDS-1];
    int          errors;
    int          checks;
    int          cycles;

    mem_access_stage i_mem_access_stage (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .tlb         (tlb),
        .cp0         (cp0),
        .prior_exc   (prior_exc),
        .prior_code  (prior_code),
        .pc          (pc),
        .overflow    (overflow),
        .trap        (trap),
        .interrupt   (interrupt),
        .eret        (eret),
        .bus         (bus),
        .mem_en      (mem_en),
        .exc         (exc),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act, input int rec);
        $display("Mismatch %s record %0d: expected %h, got %h", name, rec, exp, act);
        errors++;
    endtask

    task automatic apply_record(input int i);
        int         b;
        mem_req_t   r;
        tlb_resp_t  t;
        cp0_state_t c;
        b = i * WORDS;
        r.vaddr      = pat[b];
        r.store_data = pat[b+1];
        r.op         = mem_op_e'(pat[b+2][7:4]);
        r.is_load    = pat[b+2][3];
        r.is_store   = pat[b+2][2];
        r.is_ll      = pat[b+2][1];
        r.is_sc      = pat[b+2][0];
        if (!r.is_store)
            r.store_data = $urandom;   // rt is free for loads
        t.found        = pat[b+3][26];
        t.valid        = pat[b+3][25];
        t.dirty        = pat[b+3][24];
        t.pfn          = pat[b+3][23:4];
        t.cca          = pat[b+3][2:0];
        c.status_bev   = pat[b+4][6];
        c.status_exl   = pat[b+4][5];
        c.cause_iv     = pat[b+4][4];
        c.config_k0    = pat[b+4][2:0];
        c.ebase        = pat[b+5];
        c.epc          = pat[b+6];
        req        <= r;
        tlb        <= t;
        cp0        <= c;
        prior_exc  <= pat[b+7][12];
        prior_code <= exc_code_e'(pat[b+7][8:4]);
        overflow   <= pat[b+7][3];
        trap       <= pat[b+7][2];
        interrupt  <= pat[b+7][1];
        eret       <= pat[b+7][0];
        pc         <= pat[b+8];
    endtask

    task automatic check_record(input int i);
        int b;
        b = i * WORDS;
        checks++;
        if (bus.paddr !== pat[b+9])
            report_mismatch("bus.paddr", pat[b+9], bus.paddr, i);
        if (bus.uncached !== pat[b+10][16])
            report_mismatch("bus.uncached", 32'(pat[b+10][16]), 32'(bus.uncached), i);
        if (bus.wstrb !== pat[b+10][15:12])
            report_mismatch("bus.wstrb", 32'(pat[b+10][15:12]), 32'(bus.wstrb), i);
        if (bus.rstrb !== pat[b+10][8:4])
            report_mismatch("bus.rstrb", 32'(pat[b+10][8:4]), 32'(bus.rstrb), i);
        if (bus.size !== pat[b+10][1:0])
            report_mismatch("bus.size", 32'(pat[b+10][1:0]), 32'(bus.size), i);
        if (req.is_store && bus.wdata !== pat[b+11])
            report_mismatch("bus.wdata", pat[b+11], bus.wdata, i);
        if (mem_en !== pat[b+12][12])
            report_mismatch("mem_en", 32'(pat[b+12][12]), 32'(mem_en), i);
        if (exc.exception !== pat[b+12][10])
            report_mismatch("exc.exception", 32'(pat[b+12][10]), 32'(exc.exception), i);
        if (exc.refill !== pat[b+12][9])
            report_mismatch("exc.refill", 32'(pat[b+12][9]), 32'(exc.refill), i);
        if (redirect !== pat[b+12][8])
            report_mismatch("redirect", 32'(pat[b+12][8]), 32'(redirect), i);
        // code and badvaddr only carry meaning with an exception
        if (pat[b+12][10]) begin
            if (exc.code !== pat[b+12][4:0])
                report_mismatch("exc.code", 32'(pat[b+12][4:0]), 32'(exc.code), i);
            if (exc.badvaddr !== pat[b+13])
                report_mismatch("exc.badvaddr", pat[b+13], exc.badvaddr, i);
        end
        if (redirect_pc !== pat[b+14])
            report_mismatch("redirect_pc", pat[b+14], redirect_pc, i);
    endtask

    // run limit
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= MAX_CYC) begin
                $display("Timeout: replay did not finish within %0d cycles", MAX_CYC);
                $display("Result: FAILED");
                $finish;
            end
        end
    end

    initial begin
        errors     = 0;
        checks     = 0;
        void'($urandom(32'h7464));
        rst        = 1'b1;
        req        = '0;
        tlb        = '0;
        cp0        = '0;
        prior_exc  = 1'b0;
        prior_code = EXC_INT;
        pc         = 32'd0;
        overflow   = 1'b0;
        trap       = 1'b0;
        interrupt  = 1'b0;
        eret       = 1'b0;
        $readmemh("bench/mem_access_patterns.hex", pat);
        if ($isunknown(pat[NREC*WORDS-1]) || pat[NREC*WORDS-1] == 32'd0) begin
            $display("Pattern file missing or shorter than %0d records", NREC);
            errors++;
        end
        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < NREC; i++) begin
            @(posedge clk);
            apply_record(i);
            @(negedge clk);
            check_record(i);
        end
        $display("Records checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: bench/mem_access_patterns.hex
// in: vaddr sdata {op,ld,st,ll,sc} {fvd,pfn,cca} {bev exl iv,k0} ebase epc {prior,code,ov tr int eret} pc
// out: paddr {unc,wstrb,rstrb,size} wdata {mem_en,exc refill redirect,code} badvaddr redirect_pc
80001000 11223344 25 7123453 43 80000000 00400100 0000 00400000 00001000 0f1f2 11223344 0001 80001000 bfc00380
80001000 00000000 ba 7123453 43 80000000 00400100 0000 00400000 00001000 0f1f2 00000000 1001 80001000 bfc00380
80001000 aabbccdd 25 7123453 43 80000000 00400100 0000 00400000 00001000 0f1f2 aabbccdd 1001 80001000 bfc00380
80001004 aabbccdd 25 7123453 43 80000000 00400100 0000 00400000 00001004 0f1f2 aabbccdd 0001 80001004 bfc00380
80001000 00000000 ba 7123453 43 80000000 00400100 0000 00400000 00001000 0f1f2 00000000 1001 80001000 bfc00380
80002000 00000000 b8 7123453 43 80000000 00400100 0008 00400000 00002000 0f1f2 00000000 050c 00000000 bfc00380
80001000 55667788 25 7123453 43 80000000 00400100 0000 00400000 00001000 0f1f2 55667788 0001 80001000 bfc00380
00403abd 00000000 58 7123452 43 80000000 00400100 0000 00400000 12345abd 1f010 00000000 1001 00403abd bfc00380
a0000006 0000beef 14 7123453 43 80000000 00400100 0000 00400000 00000006 1c1f1 beefbeef 1001 a0000006 bfc00380
80000003 000000a5 04 7123453 42 80000000 00400100 0000 00400000 00000003 181f0 a5a5a5a5 1001 80000003 bfc00380
00001230 00000000 b8 0123453 43 80000000 00400100 0000 00400000 12345230 0f1f2 00000000 0702 00001230 bfc00200
00001238 01020304 24 5123453 43 80000000 00400100 0000 00400000 12345238 0f1f2 01020304 0503 00001238 bfc00380
c0000100 0a0b0c0d 24 6123453 43 80000000 00400100 0000 00400000 12345100 0f1f2 0a0b0c0d 0501 c0000100 bfc00380
80000102 12345678 24 7123453 53 80000000 00400100 104e 00400000 00000102 0f1f2 12345678 0500 00000000 bfc00400
80000101 00000000 b8 7123453 43 80000000 00400100 104c 00400010 00000101 0f1f2 00000000 0504 00400010 bfc00380
80000202 00000000 24 7123453 43 80000000 00400100 0004 00400000 00000202 0f1f2 00000000 050d 00000000 bfc00380
80000301 00000000 24 7123453 43 80000000 00400100 0000 00400000 00000301 0f1f2 00000000 0505 80000301 bfc00380
80000005 00000000 88 7123453 43 80000000 00400100 0000 00400000 00000005 0f0c1 00000000 0504 80000005 bfc00380
80000000 00000000 00 7123453 43 80000000 00400100 0001 00400000 00000000 011f0 00000000 0101 80000000 00400100
80000400 00000000 b8 7123453 03 80000000 00400100 0008 00400000 00000400 0f1f2 00000000 050c 00000000 80000180
80000010 11223344 34 7123453 43 80000000 00400100 0000 00400000 00000010 011f2 11111111 1001 80000010 bfc00380
80000011 11223344 34 7123453 43 80000000 00400100 0000 00400000 00000011 031f2 11221122 1001 80000011 bfc00380
80000012 11223344 34 7123453 43 80000000 00400100 0000 00400000 00000012 071f2 00112233 1001 80000012 bfc00380
80000013 11223344 34 7123453 43 80000000 00400100 0000 00400000 00000013 0f1f2 11223344 1001 80000013 bfc00380
80000010 11223344 44 7123453 43 80000000 00400100 0000 00400000 00000010 0f1f2 11223344 1001 80000010 bfc00380
80000011 11223344 44 7123453 43 80000000 00400100 0000 00400000 00000011 0e1f2 22334400 1001 80000011 bfc00380
80000012 11223344 44 7123453 43 80000000 00400100 0000 00400000 00000012 0c1f2 33443344 1001 80000012 bfc00380
80000013 11223344 44 7123453 43 80000000 00400100 0000 00400000 00000013 081f2 44444444 1001 80000013 bfc00380
80000012 00000000 98 7123453 43 80000000 00400100 0000 00400000 00000012 0f1e2 00000000 1001 80000012 bfc00380
80000011 00000000 a8 7123453 43 80000000 00400100 0000 00400000 00000011 0f172 00000000 1001 80000011 bfc00380
80000012 00000000 78 7123453 43 80000000 00400100 0000 00400000 00000012 0f061 00000000 1001 80000012 bfc00380
80000013 00000000 68 7123453 43 80000000 00400100 0000 00400000 00000013 0f0b0 00000000 1001 80000013 bfc00380

// File: build.f
common/mem_stage_pkg.sv
mem_stage/addr_translate.sv
mem_stage/except_detect.sv
mem_stage/ll_sc_monitor.sv
mem_stage/access_align.sv
hw/exc_vector.sv
hw/mem_access_stage.sv
bench/tb_mem_access_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run from the project root, verdict comes from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_access_stage \
    -f build.f -o sim_mem_access \
    && ./obj_dir/sim_mem_access > sim.log 2>&1 \
    || { echo "compile or run error, see sim.log"; exit 1; }

grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "no verdict in sim.log"; exit 1; }
echo "simulation passed"
